/* filelist.f */
+incdir+.
fetch_pkg.sv
branch_predictor.sv
fetch_stage.sv
instr_store.sv
fetch_top.sv
tb_fetch.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module tb_fetch -o sim_fetch

./obj_dir/sim_fetch | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* tb_fetch.sv */
// self-checking testbench for fetch_top; assumes 32-bit PC, random stimulus with fixed seed 17043
`default_nettype none
`timescale 1ns/1ps

`include "fetch_config.svh"

module tb_fetch;
    localparam int unsigned BTB_IDX_BITS  = $clog2(`FETCH_BTB_ENTRIES);
    localparam int unsigned PAGE_IDX_BITS = $clog2(`FETCH_PAGES);
    localparam int unsigned MEM_BYTES     = `FETCH_IMEM_WORDS * 4;
    localparam int unsigned RESET_CYCLES  = 8;
    localparam int unsigned N_SEQ   = 40;
    localparam int unsigned N_MIX   = 200;
    localparam int unsigned N_MISAL = 20;
    localparam int unsigned N_FAULT = 200;
    localparam int unsigned N_BPRED = 300;
    localparam int unsigned N_INVAL = 100;
    // reset and load cycles, then every test length and a margin of 100
    localparam int unsigned CYCLE_LIMIT = RESET_CYCLES + `FETCH_IMEM_WORDS + N_SEQ + N_MIX +
        N_MISAL + N_FAULT + N_BPRED + N_INVAL + 100;

    logic                             clk_i;
    logic                             rstn_i;
    fetch_pkg::pc_t                   reset_addr_i;
    fetch_pkg::fetch_ctrl_t           fetch_ctrl_i;
    fetch_pkg::pc_t                   pc_jump_i;
    logic                             invalidate_icache_i;
    fetch_pkg::exe_bpred_update_t     bpred_update_i;
    logic                             imem_we_i;
    logic [`FETCH_IMEM_ADDR_BITS-1:0] imem_waddr_i;
    logic [31:0]                      imem_wdata_i;
    logic                             page_mask_we_i;
    logic [`FETCH_PAGES-1:0]          page_mask_i;
    fetch_pkg::fetch_packet_t         fetch_o;

    // reference model state
    fetch_pkg::pc_t          m_pc;
    logic [31:0]             m_mem    [`FETCH_IMEM_WORDS];
    logic [`FETCH_PAGES-1:0] m_mask;
    logic                    m_valid  [`FETCH_BTB_ENTRIES];
    fetch_pkg::pc_t          m_bpc    [`FETCH_BTB_ENTRIES];
    fetch_pkg::pc_t          m_target [`FETCH_BTB_ENTRIES];
    logic [1:0]              m_cnt    [`FETCH_BTB_ENTRIES];

    int unsigned errors = 0;
    int unsigned checks = 0;
    int unsigned cycles = 0;
    bit          check_en = 1'b0;

    fetch_top dut_i (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .reset_addr_i        (reset_addr_i),
        .fetch_ctrl_i        (fetch_ctrl_i),
        .pc_jump_i           (pc_jump_i),
        .invalidate_icache_i (invalidate_icache_i),
        .bpred_update_i      (bpred_update_i),
        .imem_we_i           (imem_we_i),
        .imem_waddr_i        (imem_waddr_i),
        .imem_wdata_i        (imem_wdata_i),
        .page_mask_we_i      (page_mask_we_i),
        .page_mask_i         (page_mask_i),
        .fetch_o             (fetch_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // watchdog
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic int unsigned btb_idx(input fetch_pkg::pc_t pc);
        return int'(pc[BTB_IDX_BITS+1:2]);
    endfunction

    // entry valid and upper pc bits equal
    function automatic logic btb_hit(input fetch_pkg::pc_t pc);
        int unsigned idx;
        idx = btb_idx(pc);
        return m_valid[idx] && ((m_bpc[idx] >> (BTB_IDX_BITS + 2)) == (pc >> (BTB_IDX_BITS + 2)));
    endfunction

    function automatic fetch_pkg::pc_t mem_addr();
        return fetch_pkg::pc_t'($urandom_range(0, `FETCH_IMEM_WORDS - 1) * 4);
    endfunction

    // small window so trained entries get hit and replaced
    function automatic fetch_pkg::pc_t win_addr();
        return fetch_pkg::pc_t'($urandom_range(0, 63) * 4);
    endfunction

    task automatic compare_field(input string field, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail at %0t: %s is %h, expected %h", $time, field, got, exp);
            errors++;
        end
    endtask

    task automatic check_outputs();
        fetch_pkg::pc_t pc;
        int unsigned    idx;
        logic           misal;
        logic           in_range;
        logic           resp_v;
        logic           acc;
        logic           pg;
        logic           xv;
        logic           pred;
        logic [31:0]    inst;
        fetch_pkg::xcpt_cause_e cause;
        pc       = m_pc;
        idx      = btb_idx(pc);
        misal    = |pc[1:0];
        in_range = pc < MEM_BYTES;
        resp_v   = !misal && !fetch_ctrl_i.stall && !invalidate_icache_i;
        acc      = resp_v && !in_range;
        pg       = resp_v && in_range && m_mask[pc[`FETCH_PAGE_BITS +: PAGE_IDX_BITS]];
        inst     = in_range ? m_mem[pc[`FETCH_IMEM_ADDR_BITS+1:2]] : 32'h0;
        xv       = misal || acc || pg;
        // misaligned beats access beats page
        if (misal) begin
            cause = fetch_pkg::INSTR_ADDR_MISALIGNED;
        end else if (acc) begin
            cause = fetch_pkg::INSTR_ACCESS_FAULT;
        end else begin
            cause = fetch_pkg::INSTR_PAGE_FAULT;
        end
        pred = btb_hit(pc) && m_cnt[idx][1];
        compare_field("valid", fetch_o.valid, resp_v || xv);
        compare_field("pc", fetch_o.pc, pc);
        compare_field("inst", fetch_o.inst, inst);
        compare_field("xcpt.valid", fetch_o.xcpt.valid, xv);
        if (xv) begin
            compare_field("xcpt.cause", fetch_o.xcpt.cause, cause);
            compare_field("xcpt.origin", fetch_o.xcpt.origin, pc);
        end
        compare_field("bpred.decision", fetch_o.bpred.decision, pred);
        // only trained entries hold a known target
        if (m_valid[idx]) begin
            compare_field("bpred.pred_addr", fetch_o.bpred.pred_addr, m_target[idx]);
        end
    endtask

    // state change at the rising edge where next pc reads the table before training
    task automatic model_clock();
        int unsigned idx;
        int unsigned uidx;
        idx = btb_idx(m_pc);
        case (fetch_ctrl_i.next_pc_sel)
            fetch_pkg::NEXT_PC_KEEP: m_pc = m_pc;
            fetch_pkg::NEXT_PC_JUMP: m_pc = pc_jump_i;
            default: m_pc = (btb_hit(m_pc) && m_cnt[idx][1]) ? m_target[idx] : m_pc + 4;
        endcase
        if (bpred_update_i.valid) begin
            uidx = btb_idx(bpred_update_i.pc);
            if (!btb_hit(bpred_update_i.pc)) begin
                m_cnt[uidx] = bpred_update_i.taken ? 2'd2 : 2'd1;
            end else if (bpred_update_i.taken) begin
                m_cnt[uidx] = (m_cnt[uidx] == 2'd3) ? 2'd3 : m_cnt[uidx] + 2'd1;
            end else begin
                m_cnt[uidx] = (m_cnt[uidx] == 2'd0) ? 2'd0 : m_cnt[uidx] - 2'd1;
            end
            m_valid[uidx]  = 1'b1;
            m_bpc[uidx]    = bpred_update_i.pc;
            m_target[uidx] = bpred_update_i.target;
        end
        if (imem_we_i) m_mem[imem_waddr_i] = imem_wdata_i;
        if (page_mask_we_i) m_mask = page_mask_i;
    endtask

    task automatic step();
        @(posedge clk_i);
        model_clock();
        @(negedge clk_i);
        if (check_en) check_outputs();
    endtask

    task automatic drive_idle();
        fetch_ctrl_i.next_pc_sel = fetch_pkg::NEXT_PC_KEEP;
        fetch_ctrl_i.stall       = 1'b0;
        pc_jump_i                = '0;
        invalidate_icache_i      = 1'b0;
        bpred_update_i           = '0;
        imem_we_i                = 1'b0;
        imem_waddr_i             = '0;
        imem_wdata_i             = '0;
        page_mask_we_i           = 1'b0;
        page_mask_i              = '0;
    endtask

    // one random stimulus flavour per mode with inputs set at the falling edge
    task automatic run_test(input string name, input int unsigned mode, input int unsigned n);
        int unsigned err_mark;
        int unsigned r;
        err_mark = errors;
        for (int unsigned i = 0; i < n; i++) begin
            drive_idle();
            r = $urandom_range(0, 3);
            case (mode)
                1: fetch_ctrl_i.next_pc_sel = fetch_pkg::NEXT_PC_BP_OR_PLUS4;
                2: begin
                    if (r == 1) fetch_ctrl_i.next_pc_sel = fetch_pkg::NEXT_PC_JUMP;
                    if (r == 2) fetch_ctrl_i.stall = 1'b1;
                    if (r == 3) fetch_ctrl_i.next_pc_sel = fetch_pkg::NEXT_PC_BP_OR_PLUS4;
                    pc_jump_i = mem_addr();
                end
                3: begin
                    fetch_ctrl_i.next_pc_sel = fetch_pkg::NEXT_PC_JUMP;
                    pc_jump_i = mem_addr() | fetch_pkg::pc_t'($urandom_range(1, 3));
                    invalidate_icache_i = (r != 0);
                end
                4: begin
                    fetch_ctrl_i.next_pc_sel = fetch_pkg::NEXT_PC_JUMP;
                    if (r == 1) pc_jump_i = fetch_pkg::pc_t'($urandom);
                    if (r == 2) pc_jump_i = fetch_pkg::pc_t'($urandom) & ~fetch_pkg::pc_t'(3);
                    if (r == 3) pc_jump_i = mem_addr();
                    if (i == 0 || r == 0) begin
                        page_mask_we_i = 1'b1;
                        page_mask_i    = $urandom;
                        pc_jump_i      = mem_addr();
                    end
                end
                5: begin
                    bpred_update_i.valid  = $urandom_range(0, 1);
                    bpred_update_i.pc     = win_addr();
                    bpred_update_i.target = win_addr();
                    // biased toward taken so counters saturate
                    bpred_update_i.taken  = (r != 0);
                    fetch_ctrl_i.next_pc_sel = ($urandom_range(0, 3) == 0) ?
                        fetch_pkg::NEXT_PC_JUMP : fetch_pkg::NEXT_PC_BP_OR_PLUS4;
                    pc_jump_i = win_addr();
                end
                default: begin
                    invalidate_icache_i = (r == 0);
                    fetch_ctrl_i.next_pc_sel = ($urandom_range(0, 7) == 0) ?
                        fetch_pkg::NEXT_PC_JUMP : fetch_pkg::NEXT_PC_BP_OR_PLUS4;
                    pc_jump_i = mem_addr();
                end
            endcase
            step();
        end
        $display("%s: %0d cycles, %0d errors", name, n, errors - err_mark);
    endtask

    initial begin
        void'($urandom(17043));
        drive_idle();
        reset_addr_i = fetch_pkg::pc_t'($urandom_range(0, 63) * 4);
        rstn_i       = 1'b0;
        m_pc         = reset_addr_i;
        m_mask       = '0;
        for (int i = 0; i < `FETCH_BTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
            m_cnt[i]   = 2'd1;
        end
        repeat (RESET_CYCLES) @(negedge clk_i);
        rstn_i = 1'b1;
        // fill the store while KEEP holds the pc
        for (int i = 0; i < `FETCH_IMEM_WORDS; i++) begin
            drive_idle();
            imem_we_i    = 1'b1;
            imem_waddr_i = i[`FETCH_IMEM_ADDR_BITS-1:0];
            imem_wdata_i = $urandom;
            step();
        end
        drive_idle();
        check_en = 1'b1;
        compare_field("pc after reset", fetch_o.pc, reset_addr_i);
        check_outputs();
        run_test("sequential fetch", 1, N_SEQ);
        run_test("keep jump stall mix", 2, N_MIX);
        run_test("misaligned jumps", 3, N_MISAL);
        run_test("access and page faults", 4, N_FAULT);
        run_test("branch prediction", 5, N_BPRED);
        run_test("icache invalidate", 6, N_INVAL);
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* fetch_top.sv */
// fetch front end top; single clock domain, store answers in the cycle it is asked
`default_nettype none
`timescale 1ns/1ps

`include "fetch_config.svh"

module fetch_top (
    input  wire logic                             clk_i,
    input  wire logic                             rstn_i,
    input  wire fetch_pkg::pc_t                   reset_addr_i,
    input  wire fetch_pkg::fetch_ctrl_t           fetch_ctrl_i,
    input  wire fetch_pkg::pc_t                   pc_jump_i,
    input  wire logic                             invalidate_icache_i,
    input  wire fetch_pkg::exe_bpred_update_t     bpred_update_i,
    input  wire logic                             imem_we_i,
    input  wire logic [`FETCH_IMEM_ADDR_BITS-1:0] imem_waddr_i,
    input  wire logic [31:0]                      imem_wdata_i,
    input  wire logic                             page_mask_we_i,
    input  wire logic [`FETCH_PAGES-1:0]          page_mask_i,
    output fetch_pkg::fetch_packet_t              fetch_o
);
    // request and response between the two halves
    fetch_pkg::imem_req_t  imem_req;
    fetch_pkg::imem_resp_t imem_resp;

    fetch_stage fetch_i (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .reset_addr_i        (reset_addr_i),
        .fetch_ctrl_i        (fetch_ctrl_i),
        .pc_jump_i           (pc_jump_i),
        .invalidate_icache_i (invalidate_icache_i),
        .bpred_update_i      (bpred_update_i),
        .imem_resp_i         (imem_resp),
        .imem_req_o          (imem_req),
        .fetch_o             (fetch_o)
    );

    // stands in for the icache
    instr_store imem_i (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .req_i          (imem_req),
        .we_i           (imem_we_i),
        .waddr_i        (imem_waddr_i),
        .wdata_i        (imem_wdata_i),
        .page_mask_we_i (page_mask_we_i),
        .page_mask_i    (page_mask_i),
        .resp_o         (imem_resp)
    );

endmodule

`default_nettype wire

/* instr_store.sv */
// word memory with same-cycle read; no reset on contents, page mask resets to all mapped
`default_nettype none
`timescale 1ns/1ps

`include "fetch_config.svh"

module instr_store (
    input  wire logic                             clk_i,
    input  wire logic                             rstn_i,
    input  wire fetch_pkg::imem_req_t             req_i,
    input  wire logic                             we_i,
    input  wire logic [`FETCH_IMEM_ADDR_BITS-1:0] waddr_i,
    input  wire logic [31:0]                      wdata_i,
    input  wire logic                             page_mask_we_i,
    input  wire logic [`FETCH_PAGES-1:0]          page_mask_i,
    output fetch_pkg::imem_resp_t                 resp_o
);
    localparam int unsigned PAGE_IDX_BITS = (`FETCH_PAGES > 1) ? $clog2(`FETCH_PAGES) : 1;

    // first byte address past the store
    localparam fetch_pkg::pc_t MEM_END = fetch_pkg::pc_t'(`FETCH_IMEM_WORDS * 4);

    logic [31:0] mem_q [`FETCH_IMEM_WORDS];

    // set bit marks the page unmapped
    logic [`FETCH_PAGES-1:0] page_mask_q;

    logic [`FETCH_IMEM_ADDR_BITS-1:0] rd_idx;
    logic [PAGE_IDX_BITS-1:0]         page_idx;
    logic                             out_of_range;
    logic                             page_unmapped;

    // load port from the testbench
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // config register
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            page_mask_q <= '0;
        end else if (page_mask_we_i) begin
            page_mask_q <= page_mask_i;
        end
    end

    // word index, wraps past the end but data is zeroed then
    assign rd_idx   = req_i.vaddr[`FETCH_IMEM_ADDR_BITS+1:2];
    assign page_idx = req_i.vaddr[`FETCH_PAGE_BITS +: PAGE_IDX_BITS];

    assign out_of_range  = (req_i.vaddr >= MEM_END);
    assign page_unmapped = page_mask_q[page_idx];

    // invalidate kills the answer for this cycle
    always_comb begin
        resp_o.valid        = req_i.valid && !req_i.invalidate;
        resp_o.access_fault = out_of_range;
        resp_o.page_fault   = page_unmapped && !out_of_range;
        if (out_of_range) begin
            resp_o.data = '0;
        end else begin
            resp_o.data = mem_q[rd_idx];
        end
    end

    // one fault cause at a time
    a_one_fault: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !(resp_o.access_fault && resp_o.page_fault)
    ) else $error("access and page fault together");

endmodule

`default_nettype wire

/* fetch_stage.sv */
// pc register and fetch packet; PC moves every edge so stall needs KEEP, misaligned pc never reaches the store
`default_nettype none
`timescale 1ns/1ps

module fetch_stage (
    input  wire logic                         clk_i,
    input  wire logic                         rstn_i,
    input  wire fetch_pkg::pc_t               reset_addr_i,
    input  wire fetch_pkg::fetch_ctrl_t       fetch_ctrl_i,
    input  wire fetch_pkg::pc_t               pc_jump_i,
    input  wire logic                         invalidate_icache_i,
    input  wire fetch_pkg::exe_bpred_update_t bpred_update_i,
    input  wire fetch_pkg::imem_resp_t        imem_resp_i,
    output fetch_pkg::imem_req_t              imem_req_o,
    output fetch_pkg::fetch_packet_t          fetch_o
);
    fetch_pkg::pc_t pc_q;
    fetch_pkg::pc_t next_pc;

    // exception flags
    logic misaligned;
    logic access_fault;
    logic page_fault;

    fetch_pkg::fetch_xcpt_t xcpt;

    // predictor outputs
    logic           bp_hit;
    logic           bp_taken;
    fetch_pkg::pc_t bp_target;

    // next pc mux
    always_comb begin
        unique case (fetch_ctrl_i.next_pc_sel)
            fetch_pkg::NEXT_PC_KEEP: begin
                next_pc = pc_q;
            end
            fetch_pkg::NEXT_PC_BP_OR_PLUS4: begin
                if (bp_hit && bp_taken) begin
                    next_pc = bp_target;
                end else begin
                    next_pc = pc_q + fetch_pkg::pc_t'(4);
                end
            end
            fetch_pkg::NEXT_PC_JUMP: begin
                next_pc = pc_jump_i;
            end
            default: begin
                // unused encoding falls through to pc plus 4
                next_pc = pc_q + fetch_pkg::pc_t'(4);
            end
        endcase
    end

    // reset vector comes from a port
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= reset_addr_i;
        end else begin
            pc_q <= next_pc;
        end
    end

    // misaligned is raised locally while faults come back from the store
    assign misaligned   = |pc_q[1:0];
    assign access_fault = imem_resp_i.valid && imem_resp_i.access_fault;
    assign page_fault   = imem_resp_i.valid && imem_resp_i.page_fault;

    // request only for aligned pc when not stalled
    assign imem_req_o.valid      = !misaligned && !fetch_ctrl_i.stall;
    assign imem_req_o.vaddr      = pc_q;
    assign imem_req_o.invalidate = invalidate_icache_i;

    // misaligned ahead of access fault ahead of page fault
    always_comb begin
        xcpt.origin = pc_q;
        xcpt.valid  = 1'b1;
        if (misaligned) begin
            xcpt.cause = fetch_pkg::INSTR_ADDR_MISALIGNED;
        end else if (access_fault) begin
            xcpt.cause = fetch_pkg::INSTR_ACCESS_FAULT;
        end else if (page_fault) begin
            xcpt.cause = fetch_pkg::INSTR_PAGE_FAULT;
        end else begin
            xcpt.cause = fetch_pkg::INSTR_ADDR_MISALIGNED;
            xcpt.valid = 1'b0;
        end
    end

    // packet is combinational on the current pc
    always_comb begin
        // store faults come with a valid response and misaligned is the only extra case
        fetch_o.valid = imem_resp_i.valid || misaligned;
        fetch_o.pc    = pc_q;
        fetch_o.inst  = imem_resp_i.data;
        fetch_o.xcpt  = xcpt;
        fetch_o.bpred.decision = (bp_hit && bp_taken) ? fetch_pkg::PRED_TAKEN
                                                      : fetch_pkg::PRED_NOT_TAKEN;
        fetch_o.bpred.pred_addr = bp_target;
    end

    branch_predictor bpred_i (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .pc_fetch_i (pc_q),
        .update_i   (bpred_update_i),
        .hit_o      (bp_hit),
        .taken_o    (bp_taken),
        .target_o   (bp_target)
    );

    // a misaligned pc is reported as such and never reaches the store
    a_req_aligned: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        misaligned |-> !imem_req_o.valid && fetch_o.xcpt.valid &&
            (fetch_o.xcpt.cause == fetch_pkg::INSTR_ADDR_MISALIGNED)
    ) else $error("misaligned pc sent to the store or not reported");

    // faults from the store always surface as a valid packet
    a_xcpt_valid: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        fetch_o.xcpt.valid |-> fetch_o.valid
    ) else $error("exception without valid fetch");

endmodule

`default_nettype wire

/* branch_predictor.sv */
// direct-mapped btb with 2-bit counters; an update at edge N is visible from cycle N+1, no aliasing guard
`default_nettype none
`timescale 1ns/1ps

`include "fetch_config.svh"

module branch_predictor (
    input  wire logic                        clk_i,
    input  wire logic                        rstn_i,
    input  wire fetch_pkg::pc_t              pc_fetch_i,
    input  wire fetch_pkg::exe_bpred_update_t update_i,
    output logic                             hit_o,
    output logic                             taken_o,
    output fetch_pkg::pc_t                   target_o
);
    localparam int unsigned IDX_BITS = $clog2(`FETCH_BTB_ENTRIES);
    localparam int unsigned TAG_BITS = `FETCH_PC_BITS - IDX_BITS - 2;

    // per entry state
    logic [`FETCH_BTB_ENTRIES-1:0] valid_q;
    logic [TAG_BITS-1:0]           tag_q    [`FETCH_BTB_ENTRIES];
    fetch_pkg::pc_t                target_q [`FETCH_BTB_ENTRIES];
    logic [1:0]                    cnt_q    [`FETCH_BTB_ENTRIES];

    // lookup side
    logic [IDX_BITS-1:0] fetch_idx;
    logic [TAG_BITS-1:0] fetch_tag;

    // update side
    logic [IDX_BITS-1:0] upd_idx;
    logic [TAG_BITS-1:0] upd_tag;
    logic                upd_match;
    logic [1:0]          upd_cnt;

    assign fetch_idx = pc_fetch_i[IDX_BITS+1:2];
    assign fetch_tag = pc_fetch_i[`FETCH_PC_BITS-1:IDX_BITS+2];

    // combinational read
    assign hit_o    = valid_q[fetch_idx] && (tag_q[fetch_idx] == fetch_tag);
    assign taken_o  = cnt_q[fetch_idx][1];
    assign target_o = target_q[fetch_idx];

    assign upd_idx   = update_i.pc[IDX_BITS+1:2];
    assign upd_tag   = update_i.pc[`FETCH_PC_BITS-1:IDX_BITS+2];
    assign upd_match = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);

    // next counter value for the trained entry
    always_comb begin
        if (!upd_match) begin
            // fresh entry, start weakly toward the outcome
            upd_cnt = update_i.taken ? 2'd2 : 2'd1;
        end else if (update_i.taken) begin
            upd_cnt = (cnt_q[upd_idx] == 2'd3) ? 2'd3 : cnt_q[upd_idx] + 2'd1;
        end else begin
            upd_cnt = (cnt_q[upd_idx] == 2'd0) ? 2'd0 : cnt_q[upd_idx] - 2'd1;
        end
    end

    // control state: valid bits and counters
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
            for (int i = 0; i < `FETCH_BTB_ENTRIES; i++) begin
                // weakly not taken
                cnt_q[i] <= 2'd1;
            end
        end else if (update_i.valid) begin
            valid_q[upd_idx] <= 1'b1;
            cnt_q[upd_idx]   <= upd_cnt;
        end
    end

    // tag and target payload
    always_ff @(posedge clk_i) begin
        if (update_i.valid) begin
            tag_q[upd_idx]    <= upd_tag;
            target_q[upd_idx] <= update_i.target;
        end
    end

    // counter never wraps between 0 and 3 on a training hit
    a_cnt_no_wrap: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (update_i.valid && upd_match) |=>
            !(($past(cnt_q[upd_idx]) == 2'd3) && (cnt_q[$past(upd_idx)] == 2'd0)) &&
            !(($past(cnt_q[upd_idx]) == 2'd0) && (cnt_q[$past(upd_idx)] == 2'd3))
    ) else $error("btb counter wrapped");

endmodule

`default_nettype wire

/* fetch_pkg.sv */
// shared fetch types; widths follow fetch_config.svh, instructions are fixed at 32 bits
`default_nettype none

`include "fetch_config.svh"

package fetch_pkg;

    // program counter / virtual address
    typedef logic [`FETCH_PC_BITS-1:0] pc_t;

    // next pc source chosen by the control unit
    typedef enum logic [1:0] {
        NEXT_PC_KEEP        = 2'd0,
        NEXT_PC_BP_OR_PLUS4 = 2'd1,
        NEXT_PC_JUMP        = 2'd2
    } next_pc_sel_e;

    // fetch exception causes, riscv mcause codes
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        INSTR_ACCESS_FAULT    = 4'd1,
        INSTR_PAGE_FAULT      = 4'd12
    } xcpt_cause_e;

    typedef enum logic {
        PRED_NOT_TAKEN = 1'b0,
        PRED_TAKEN     = 1'b1
    } bpred_decision_e;

    // control from the control unit
    typedef struct packed {
        next_pc_sel_e next_pc_sel;
        logic         stall;
    } fetch_ctrl_t;

    // request toward the instruction store
    typedef struct packed {
        logic valid;
        pc_t  vaddr;
        logic invalidate;
    } imem_req_t;

    // same-cycle answer from the store
    typedef struct packed {
        logic        valid;
        logic [31:0] data;
        logic        access_fault;
        logic        page_fault;
    } imem_resp_t;

    // resolved branch from execute
    typedef struct packed {
        logic valid;
        pc_t  pc;
        pc_t  target;
        logic taken;
    } exe_bpred_update_t;

    typedef struct packed {
        logic        valid;
        xcpt_cause_e cause;
        pc_t         origin;
    } fetch_xcpt_t;

    typedef struct packed {
        bpred_decision_e decision;
        pc_t             pred_addr;
    } bpred_t;

    // what fetch hands to decode
    typedef struct packed {
        logic        valid;
        pc_t         pc;
        logic [31:0] inst;
        fetch_xcpt_t xcpt;
        bpred_t      bpred;
    } fetch_packet_t;

endpackage

`default_nettype wire

/* fetch_config.svh */
// sizes for the fetch front end; the store must span a whole number of pages, BTB entries a power of two
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// pc and virtual address width
`define FETCH_PC_BITS 32

// instruction store depth in 32-bit words
`define FETCH_IMEM_WORDS 256

// word index width for the load port
`define FETCH_IMEM_ADDR_BITS $clog2(`FETCH_IMEM_WORDS)

// log2 of page size in bytes
`define FETCH_PAGE_BITS 8

// number of pages the store spans, one mask bit each
`define FETCH_PAGES ((`FETCH_IMEM_WORDS * 4) >> `FETCH_PAGE_BITS)

// direct-mapped btb size, indexed from pc bit 2 upward
`define FETCH_BTB_ENTRIES 16

`endif
